//--- project.f
src/l2_interconnect_pkg.sv
src/rr_arbiter.sv
src/l2_sram_bank.sv
src/tcdm_addr_decoder.sv
src/interleaved_xbar.sv
src/l2_interconnect.sv
sim/tb_l2_interconnect.sv

//--- Bender.yml
package:
  name: l2_interconnect

sources:
  # Shared types first, then leaf modules, then the top level
  - files:
      - src/l2_interconnect_pkg.sv
      - src/rr_arbiter.sv
      - src/l2_sram_bank.sv
      - src/tcdm_addr_decoder.sv
      - src/interleaved_xbar.sv
      - src/l2_interconnect.sv

  # File-driven testbench of the top level
  - target: simulation
    files:
      - sim/tb_l2_interconnect.sv

//--- sim/l2_stimulus.txt
# grp mst wen addr     be wdata    exp_data opc rnd
# wen 1 reads, rnd 1 draws random write data or expects the last write to that word
1 0 0 1C000100 F 12345678 00000000 0 0
1 0 1 1C000100 F 00000000 12345678 0 0
2 1 0 1C000200 F A1B2C3D4 00000000 0 0
2 1 0 1C000200 3 0000EEFF 00000000 0 0
2 1 1 1C000200 F 00000000 A1B2EEFF 0 0
3 0 0 1C000300 F 00000000 00000000 0 1
3 0 0 1C000304 F 00000000 00000000 0 1
3 0 0 1C000308 F 00000000 00000000 0 1
3 0 0 1C00030C F 00000000 00000000 0 1
3 0 1 1C000300 F 00000000 00000000 0 1
3 0 1 1C000304 F 00000000 00000000 0 1
3 0 1 1C000308 F 00000000 00000000 0 1
3 0 1 1C00030C F 00000000 00000000 0 1
4 0 0 1C000400 F 00000000 00000000 0 1
4 1 0 1C000440 F 00000000 00000000 0 1
4 0 0 1C000410 F 00000000 00000000 0 1
4 1 0 1C000450 F 00000000 00000000 0 1
4 0 0 1C000420 F 00000000 00000000 0 1
4 1 0 1C000460 F 00000000 00000000 0 1
5 0 1 1C000400 F 00000000 00000000 0 1
5 1 1 1C000440 F 00000000 00000000 0 1
5 0 1 1C000410 F 00000000 00000000 0 1
5 1 1 1C000450 F 00000000 00000000 0 1
5 0 1 1C000420 F 00000000 00000000 0 1
5 1 1 1C000460 F 00000000 00000000 0 1
6 0 0 1C000000 F 00000000 00000000 0 1
6 0 0 1C000004 F 00000000 00000000 0 1
6 0 1 1BFFFFFC F 00000000 BADACCE5 1 0
6 1 0 1C001000 F DEADBEEF 00000000 1 0
6 1 0 1C001004 F CAFEF00D 00000000 1 0
7 0 1 1C000000 F 00000000 00000000 0 1
7 0 1 1C000004 F 00000000 00000000 0 1
7 1 1 20000000 F 00000000 BADACCE5 1 0

//--- sim/tb_l2_interconnect.sv
// Testbench for the L2 interconnect with stimulus reader, per-master drivers, checks and summary
`timescale 1ns/10ps

module tb_l2_interconnect;

    import l2_interconnect_pkg::*;

    localparam int NR_MASTERS   = 2;
    localparam int NR_BANKS     = 4;
    localparam int BANK_WORDS   = 256;
    localparam int REGION_BYTES = NR_BANKS * BANK_WORDS * 4;
    localparam int MODEL_WORDS  = NR_BANKS * BANK_WORDS;
    localparam int CLK_PERIOD   = 40;
    // Outputs are sampled a quarter period after the falling edge and well clear of both edges
    localparam int SAMPLE_DELAY = CLK_PERIOD / 4;
    localparam int GNT_TIMEOUT  = 16;
    localparam int MAX_LINES    = 64;
    localparam int IDLE_CYCLES  = 3;

    logic                     clk_i;
    logic                     reset_i;
    logic  [NR_MASTERS-1:0]   req_i;
    addr_t [NR_MASTERS-1:0]   add_i;
    logic  [NR_MASTERS-1:0]   wen_i;
    be_t   [NR_MASTERS-1:0]   be_i;
    data_t [NR_MASTERS-1:0]   wdata_i;
    logic  [NR_MASTERS-1:0]   gnt_o;
    logic  [NR_MASTERS-1:0]   r_valid_o;
    data_t [NR_MASTERS-1:0]   r_rdata_o;
    logic  [NR_MASTERS-1:0]   r_opc_o;

    // One entry per access of the stimulus file
    int    line_grp    [MAX_LINES];
    int    line_master [MAX_LINES];
    logic  line_wen    [MAX_LINES];
    addr_t line_addr   [MAX_LINES];
    be_t   line_be     [MAX_LINES];
    data_t line_wdata  [MAX_LINES];
    data_t line_exp    [MAX_LINES];
    logic  line_opc    [MAX_LINES];
    int    nr_lines;

    // Reference image of the region that every in-region write updates in file order
    data_t model_mem [MODEL_WORDS];

    int seed;
    int data_errors;
    int flag_errors;
    int wait_errors;
    int timeouts;
    int file_errors;

    l2_interconnect #(
        .NR_MASTERS (NR_MASTERS),
        .NR_BANKS   (NR_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) dut0 (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .add_i     (add_i),
        .wen_i     (wen_i),
        .be_i      (be_i),
        .wdata_i   (wdata_i),
        .gnt_o     (gnt_o),
        .r_valid_o (r_valid_o),
        .r_rdata_o (r_rdata_o),
        .r_opc_o   (r_opc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Reference helpers
    //////////////////////////////////////////////////

    // True for byte addresses inside the interleaved region
    function automatic logic region_hit(input addr_t addr);
        return (addr >= L2_BASE_ADDR) && (addr < L2_BASE_ADDR + addr_t'(REGION_BYTES));
    endfunction

    // Byte-lane merge of a write into the word it lands on
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input be_t be);
        data_t result;
        result = old_word;
        for (int lane = 0; lane < $bits(be_t); lane++) begin
            if (be[lane]) begin
                result[8*lane +: 8] = new_word[8*lane +: 8];
            end
        end
        return result;
    endfunction

    // Finds the first access of master m at or after index from and returns last+1 if none
    function automatic int next_line(input int m, input int from, input int last);
        int k;
        k = from;
        while (k <= last && line_master[k] != m) begin
            k++;
        end
        return k;
    endfunction

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_data(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            data_errors++;
            $display("** Error at %0t: %s read data %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            flag_errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_wait(input int waited, input int limit, input string what);
        if (waited > limit) begin
            wait_errors++;
            $display("** Error at %0t: %s waited %0d cycles for grant, at most %0d allowed",
                     $time, what, waited, limit);
        end
    endtask

    // Prints the error counts and the verdict and ends the simulation
    task automatic finish_run();
        int total;
        total = data_errors + flag_errors + wait_errors + timeouts + file_errors;
        $display("Errors: data %0d, flag %0d, grant wait %0d, timeout %0d, file %0d",
                 data_errors, flag_errors, wait_errors, timeouts, file_errors);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // Stimulus reader
    //////////////////////////////////////////////////

    // Random write data is drawn here in file order so the model sees the same words
    task automatic load_stimulus();
        int    fd;
        int    n;
        int    word;
        int    t_grp;
        int    t_mst;
        int    t_wen;
        int    t_opc;
        int    t_rnd;
        addr_t t_addr;
        be_t   t_be;
        data_t t_wdata;
        data_t t_exp;
        string text;
        nr_lines = 0;
        seed = 32'h68e83a0c;
        fd = $fopen("sim/l2_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/l2_stimulus.txt");
            file_errors++;
        end else begin
            while (!$feof(fd) && nr_lines < MAX_LINES) begin
                text = "";
                n = $fgets(text, fd);
                // Comment lines start with a hash and blank lines fail the scan
                if (n > 0 && text[0] != "#") begin
                    n = $sscanf(text, "%d %d %d %h %h %h %h %d %d", t_grp, t_mst, t_wen,
                                t_addr, t_be, t_wdata, t_exp, t_opc, t_rnd);
                    if (n == 9) begin
                        word = int'((t_addr - L2_BASE_ADDR) >> 2);
                        if (t_rnd != 0 && t_wen == 0) begin
                            t_wdata = $random(seed);
                        end
                        if (t_rnd != 0 && t_wen != 0 && region_hit(t_addr)) begin
                            t_exp = model_mem[word];
                        end
                        if (t_wen == 0 && region_hit(t_addr)) begin
                            model_mem[word] = merge_bytes(model_mem[word], t_wdata, t_be);
                        end
                        line_grp[nr_lines]    = t_grp;
                        line_master[nr_lines] = t_mst;
                        line_wen[nr_lines]    = (t_wen != 0);
                        line_addr[nr_lines]   = t_addr;
                        line_be[nr_lines]     = t_be;
                        line_wdata[nr_lines]  = t_wdata;
                        line_exp[nr_lines]    = t_exp;
                        line_opc[nr_lines]    = (t_opc != 0);
                        nr_lines++;
                    end
                end
            end
            $fclose(fd);
            if (nr_lines == 0) begin
                $display("The stimulus file holds no accesses");
                file_errors++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Master driver
    //////////////////////////////////////////////////

    // Issues the accesses of master m in entries first to last with one access per grant
    // The response of each grant is due exactly one cycle later
    task automatic run_master(input int m, input int first, input int last);
        int   k;
        int   waits;
        int   pend_k;
        logic pending;
        k = next_line(m, first, last);
        waits = 0;
        pend_k = 0;
        pending = 1'b0;
        while (k <= last || pending) begin
            @(negedge clk_i);
            if (k <= last) begin
                req_i[m]   = 1'b1;
                add_i[m]   = line_addr[k];
                wen_i[m]   = line_wen[k];
                be_i[m]    = line_be[k];
                wdata_i[m] = line_wdata[k];
            end else begin
                req_i[m] = 1'b0;
            end
            #(SAMPLE_DELAY);
            if (pending) begin
                check_flag(r_valid_o[m], 1'b1,
                           $sformatf("r_valid of master %0d access %0d", m, pend_k));
                if (r_valid_o[m]) begin
                    check_flag(r_opc_o[m], line_opc[pend_k],
                               $sformatf("r_opc of master %0d access %0d", m, pend_k));
                    // Write responses carry no defined data
                    if (line_wen[pend_k]) begin
                        check_data(r_rdata_o[m], line_exp[pend_k],
                                   $sformatf("master %0d access %0d", m, pend_k));
                    end
                end
                pending = 1'b0;
            end else begin
                check_flag(r_valid_o[m], 1'b0,
                           $sformatf("r_valid of master %0d without a grant", m));
            end
            if (k <= last) begin
                if (gnt_o[m]) begin
                    check_wait(waits, NR_MASTERS - 1,
                               $sformatf("master %0d access %0d", m, k));
                    pending = 1'b1;
                    pend_k = k;
                    waits = 0;
                    k = next_line(m, k + 1, last);
                end else if (waits == GNT_TIMEOUT) begin
                    $display("Timeout: master %0d got no grant within %0d cycles for access %0d",
                             m, GNT_TIMEOUT, k);
                    timeouts++;
                    // Withdraw the request and give up on the rest of this group
                    req_i[m] = 1'b0;
                    k = last + 1;
                end else begin
                    waits++;
                end
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        int i;
        int g_last;
        data_errors = 0;
        flag_errors = 0;
        wait_errors = 0;
        timeouts = 0;
        file_errors = 0;
        reset_i = 1'b1;
        req_i   = '0;
        add_i   = '0;
        wen_i   = '0;
        be_i    = '0;
        wdata_i = '0;
        load_stimulus();
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        // Nothing may be granted or answered while no master requests
        repeat (IDLE_CYCLES) begin
            @(negedge clk_i);
            #(SAMPLE_DELAY);
            for (int m = 0; m < NR_MASTERS; m++) begin
                check_flag(gnt_o[m], 1'b0, $sformatf("gnt of idle master %0d", m));
                check_flag(r_valid_o[m], 1'b0, $sformatf("r_valid of idle master %0d", m));
            end
        end

        // Consecutive entries with one group number run on both masters at once
        // A stuck grant stops the sequence after the group it happened in
        i = 0;
        while (i < nr_lines && timeouts == 0) begin
            g_last = i;
            while (g_last + 1 < nr_lines && line_grp[g_last + 1] == line_grp[i]) begin
                g_last++;
            end
            fork
                run_master(0, i, g_last);
                run_master(1, i, g_last);
            join
            i = g_last + 1;
        end

        finish_run();
    end

endmodule : tb_l2_interconnect

//--- src/l2_interconnect.sv
// Top level of the L2 interconnect with decoders, interleaved crossbar and SRAM banks
`timescale 1ns/10ps

module l2_interconnect #(
    parameter int unsigned NR_MASTERS = 2,
    parameter int unsigned NR_BANKS   = 4,
    parameter int unsigned BANK_WORDS = 256
) (
    input  logic                                         clk_i,
    input  logic                                         reset_i,
    // Master request channels
    input  logic [NR_MASTERS-1:0]                        req_i,
    input  l2_interconnect_pkg::addr_t [NR_MASTERS-1:0]  add_i,
    input  logic [NR_MASTERS-1:0]                        wen_i,
    input  l2_interconnect_pkg::be_t [NR_MASTERS-1:0]    be_i,
    input  l2_interconnect_pkg::data_t [NR_MASTERS-1:0]  wdata_i,
    // Master response channels
    output logic [NR_MASTERS-1:0]                        gnt_o,
    output logic [NR_MASTERS-1:0]                        r_valid_o,
    output l2_interconnect_pkg::data_t [NR_MASTERS-1:0]  r_rdata_o,
    output logic [NR_MASTERS-1:0]                        r_opc_o
);

    import l2_interconnect_pkg::*;

    // Decoder to crossbar, in-region requests only
    logic  [NR_MASTERS-1:0] dec_req;
    addr_t [NR_MASTERS-1:0] dec_add;
    logic  [NR_MASTERS-1:0] dec_wen;
    be_t   [NR_MASTERS-1:0] dec_be;
    data_t [NR_MASTERS-1:0] dec_wdata;
    logic  [NR_MASTERS-1:0] dec_gnt;
    logic  [NR_MASTERS-1:0] dec_r_valid;
    data_t [NR_MASTERS-1:0] dec_r_rdata;

    // Crossbar to banks
    logic  [NR_BANKS-1:0]                          bank_req;
    logic  [NR_BANKS-1:0][$clog2(BANK_WORDS)-1:0]  bank_idx;
    logic  [NR_BANKS-1:0]                          bank_wen;
    be_t   [NR_BANKS-1:0]                          bank_be;
    data_t [NR_BANKS-1:0]                          bank_wdata;
    data_t [NR_BANKS-1:0]                          bank_rdata;

    //////////////////////////////////////////////////
    // Address decoders, one per master
    //////////////////////////////////////////////////

    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_decoder
        tcdm_addr_decoder #(
            .NR_BANKS   (NR_BANKS),
            .BANK_WORDS (BANK_WORDS)
        ) i_decoder (
            .clk_i          (clk_i),
            .reset_i        (reset_i),
            .req_i          (req_i[m]),
            .add_i          (add_i[m]),
            .wen_i          (wen_i[m]),
            .be_i           (be_i[m]),
            .wdata_i        (wdata_i[m]),
            .gnt_o          (gnt_o[m]),
            .r_valid_o      (r_valid_o[m]),
            .r_rdata_o      (r_rdata_o[m]),
            .r_opc_o        (r_opc_o[m]),
            .xbar_req_o     (dec_req[m]),
            .xbar_add_o     (dec_add[m]),
            .xbar_wen_o     (dec_wen[m]),
            .xbar_be_o      (dec_be[m]),
            .xbar_wdata_o   (dec_wdata[m]),
            .xbar_gnt_i     (dec_gnt[m]),
            .xbar_r_valid_i (dec_r_valid[m]),
            .xbar_r_rdata_i (dec_r_rdata[m])
        );
    end

    //////////////////////////////////////////////////
    // Interleaved crossbar and banks
    //////////////////////////////////////////////////

    interleaved_xbar #(
        .NR_MASTERS (NR_MASTERS),
        .NR_BANKS   (NR_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) i_interleaved_xbar (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .m_req_i      (dec_req),
        .m_add_i      (dec_add),
        .m_wen_i      (dec_wen),
        .m_be_i       (dec_be),
        .m_wdata_i    (dec_wdata),
        .m_gnt_o      (dec_gnt),
        .m_r_valid_o  (dec_r_valid),
        .m_r_rdata_o  (dec_r_rdata),
        .bank_req_o   (bank_req),
        .bank_idx_o   (bank_idx),
        .bank_wen_o   (bank_wen),
        .bank_be_o    (bank_be),
        .bank_wdata_o (bank_wdata),
        .bank_rdata_i (bank_rdata)
    );

    for (genvar b = 0; b < NR_BANKS; b++) begin : gen_bank
        l2_sram_bank #(
            .BANK_WORDS (BANK_WORDS)
        ) i_bank (
            .clk_i   (clk_i),
            .req_i   (bank_req[b]),
            .idx_i   (bank_idx[b]),
            .wen_i   (bank_wen[b]),
            .be_i    (bank_be[b]),
            .wdata_i (bank_wdata[b]),
            .rdata_o (bank_rdata[b])
        );
    end

endmodule : l2_interconnect

//--- src/interleaved_xbar.sv
// Word-interleaved crossbar with per-bank round-robin arbitration and response routing
`timescale 1ns/10ps

module interleaved_xbar #(
    parameter int unsigned NR_MASTERS = 2,
    parameter int unsigned NR_BANKS   = 4,
    parameter int unsigned BANK_WORDS = 256
) (
    input  logic                                             clk_i,
    input  logic                                             reset_i,
    // Master side request, addresses are offsets into the region
    input  logic [NR_MASTERS-1:0]                            m_req_i,
    input  l2_interconnect_pkg::addr_t [NR_MASTERS-1:0]      m_add_i,
    input  logic [NR_MASTERS-1:0]                            m_wen_i,
    input  l2_interconnect_pkg::be_t [NR_MASTERS-1:0]        m_be_i,
    input  l2_interconnect_pkg::data_t [NR_MASTERS-1:0]      m_wdata_i,
    // Master side response
    output logic [NR_MASTERS-1:0]                            m_gnt_o,
    output logic [NR_MASTERS-1:0]                            m_r_valid_o,
    output l2_interconnect_pkg::data_t [NR_MASTERS-1:0]      m_r_rdata_o,
    // Bank side
    output logic [NR_BANKS-1:0]                              bank_req_o,
    output logic [NR_BANKS-1:0][$clog2(BANK_WORDS)-1:0]      bank_idx_o,
    output logic [NR_BANKS-1:0]                              bank_wen_o,
    output l2_interconnect_pkg::be_t [NR_BANKS-1:0]          bank_be_o,
    output l2_interconnect_pkg::data_t [NR_BANKS-1:0]        bank_wdata_o,
    input  l2_interconnect_pkg::data_t [NR_BANKS-1:0]        bank_rdata_i
);

    // Number of word-address bits that pick the bank
    localparam int unsigned BANK_BITS = $clog2(NR_BANKS);
    localparam int unsigned BANK_W    = (NR_BANKS > 1) ? BANK_BITS : 1;
    localparam int unsigned IDX_W     = $clog2(BANK_WORDS);
    localparam int unsigned MST_W     = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;

    typedef logic [BANK_W-1:0] bank_sel_t;
    typedef logic [IDX_W-1:0]  word_idx_t;
    typedef logic [MST_W-1:0]  mst_idx_t;

    bank_sel_t [NR_MASTERS-1:0]                m_bank;
    word_idx_t [NR_MASTERS-1:0]                m_idx;
    logic      [NR_BANKS-1:0][NR_MASTERS-1:0]  bank_reqs;
    logic      [NR_BANKS-1:0][NR_MASTERS-1:0]  bank_gnt;
    mst_idx_t  [NR_BANKS-1:0]                  win_idx;
    logic      [NR_BANKS-1:0]                  rsp_valid_q;
    mst_idx_t  [NR_BANKS-1:0]                  rsp_owner_q;

    //////////////////////////////////////////////////
    // Address split and request routing
    //////////////////////////////////////////////////

    // Bits 1:0 are the byte offset, the next bits pick the bank
    // and the bits above those index the word inside the bank
    for (genvar m = 0; m < NR_MASTERS; m++) begin : gen_addr_split
        assign m_bank[m] = (NR_BANKS > 1) ? m_add_i[m][2 +: BANK_W] : '0;
        assign m_idx[m]  = m_add_i[m][2 + BANK_BITS +: IDX_W];
    end

    // Each bank sees a request vector with one bit per master
    always_comb begin
        for (int b = 0; b < NR_BANKS; b++) begin
            for (int m = 0; m < NR_MASTERS; m++) begin
                bank_reqs[b][m] = m_req_i[m] && (m_bank[m] == bank_sel_t'(b));
            end
        end
    end

    //////////////////////////////////////////////////
    // Per-bank arbitration
    //////////////////////////////////////////////////

    for (genvar b = 0; b < NR_BANKS; b++) begin : gen_bank_port
        rr_arbiter #(
            .NR_MASTERS (NR_MASTERS)
        ) i_rr_arbiter (
            .clk_i     (clk_i),
            .reset_i   (reset_i),
            .req_i     (bank_reqs[b]),
            .gnt_o     (bank_gnt[b]),
            .gnt_idx_o (win_idx[b])
        );

        // Banks are always ready, so any request presented is accepted
        assign bank_req_o[b]   = |bank_reqs[b];
        assign bank_idx_o[b]   = m_idx[win_idx[b]];
        assign bank_wen_o[b]   = m_wen_i[win_idx[b]];
        assign bank_be_o[b]    = m_be_i[win_idx[b]];
        assign bank_wdata_o[b] = m_wdata_i[win_idx[b]];

        // Remember which master owns next cycle's bank output
        always_ff @(posedge clk_i) begin
            if (reset_i) begin
                rsp_valid_q[b] <= 1'b0;
            end else begin
                rsp_valid_q[b] <= bank_req_o[b];
            end
        end

        always_ff @(posedge clk_i) begin
            if (bank_req_o[b]) begin
                rsp_owner_q[b] <= win_idx[b];
            end
        end
    end

    //////////////////////////////////////////////////
    // Grant and response return
    //////////////////////////////////////////////////

    // A master wins at most one bank per cycle, so one owner match at most
    always_comb begin
        m_gnt_o     = '0;
        m_r_valid_o = '0;
        m_r_rdata_o = '0;
        for (int m = 0; m < NR_MASTERS; m++) begin
            for (int b = 0; b < NR_BANKS; b++) begin
                m_gnt_o[m] = m_gnt_o[m] | bank_gnt[b][m];
                if (rsp_valid_q[b] && (rsp_owner_q[b] == mst_idx_t'(m))) begin
                    m_r_valid_o[m] = 1'b1;
                    m_r_rdata_o[m] = bank_rdata_i[b];
                end
            end
        end
    end

endmodule : interleaved_xbar

//--- src/tcdm_addr_decoder.sv
// Per-master L2 region decoder with built-in error responder and response merge
`timescale 1ns/10ps

module tcdm_addr_decoder #(
    parameter int unsigned NR_BANKS   = 4,
    parameter int unsigned BANK_WORDS = 256
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // Master side request
    input  logic                        req_i,
    input  l2_interconnect_pkg::addr_t  add_i,
    input  logic                        wen_i,
    input  l2_interconnect_pkg::be_t    be_i,
    input  l2_interconnect_pkg::data_t  wdata_i,
    // Master side response
    output logic                        gnt_o,
    output logic                        r_valid_o,
    output l2_interconnect_pkg::data_t  r_rdata_o,
    output logic                        r_opc_o,
    // Crossbar side request
    output logic                        xbar_req_o,
    output l2_interconnect_pkg::addr_t  xbar_add_o,
    output logic                        xbar_wen_o,
    output l2_interconnect_pkg::be_t    xbar_be_o,
    output l2_interconnect_pkg::data_t  xbar_wdata_o,
    // Crossbar side response
    input  logic                        xbar_gnt_i,
    input  logic                        xbar_r_valid_i,
    input  l2_interconnect_pkg::data_t  xbar_r_rdata_i
);

    import l2_interconnect_pkg::*;

    // Size of the interleaved region in bytes, all banks back to back
    localparam int unsigned REGION_BYTES = NR_BANKS * BANK_WORDS * 4;

    addr_t region_offset;
    logic  in_region;
    logic  err_req;
    logic  err_valid_q;
    logic  err_wen_q;

    //////////////////////////////////////////////////
    // Region check
    //////////////////////////////////////////////////

    // Offset of the access from the region base
    // Addresses below the base wrap to a large value here
    assign region_offset = add_i - L2_BASE_ADDR;

    assign in_region = (add_i >= L2_BASE_ADDR) && (region_offset < addr_t'(REGION_BYTES));

    // Requests that miss the region never reach the crossbar
    assign err_req    = req_i & ~in_region;
    assign xbar_req_o = req_i & in_region;

    // The crossbar sees the region offset, so bank mapping does not depend on base alignment
    assign xbar_add_o   = region_offset;
    assign xbar_wen_o   = wen_i;
    assign xbar_be_o    = be_i;
    assign xbar_wdata_o = wdata_i;

    // The error responder is always ready and grants in the request cycle
    // The crossbar grant can only be high for an in-region request
    assign gnt_o = err_req | xbar_gnt_i;

    //////////////////////////////////////////////////
    // Error responder
    //////////////////////////////////////////////////

    // One-cycle response slot of the error responder
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            err_valid_q <= 1'b0;
        end else begin
            err_valid_q <= err_req;
        end
    end

    // Read or write flag of the failed access, only needed for the data word
    always_ff @(posedge clk_i) begin
        if (err_req) begin
            err_wen_q <= wen_i;
        end
    end

    // Response merge
    // A master holds at most one grant per cycle, so the two sources never overlap
    assign r_valid_o = err_valid_q | xbar_r_valid_i;
    assign r_opc_o   = err_valid_q;

    always_comb begin
        if (err_valid_q) begin
            // Failed reads return the error word, failed writes return zero
            r_rdata_o = err_wen_q ? ERROR_RESPONSE : '0;
        end else begin
            r_rdata_o = xbar_r_rdata_i;
        end
    end

endmodule : tcdm_addr_decoder

//--- src/l2_sram_bank.sv
// Single-port SRAM bank model with byte-lane writes and one-cycle registered read
`timescale 1ns/10ps

module l2_sram_bank #(
    parameter int unsigned BANK_WORDS = 256
) (
    input  logic                           clk_i,
    input  logic                           req_i,
    input  logic [$clog2(BANK_WORDS)-1:0]  idx_i,
    input  logic                           wen_i,
    input  l2_interconnect_pkg::be_t       be_i,
    input  l2_interconnect_pkg::data_t     wdata_i,
    output l2_interconnect_pkg::data_t     rdata_o
);

    import l2_interconnect_pkg::*;

    // Number of byte lanes in a word
    localparam int unsigned NR_LANES = $bits(be_t);

    // Storage array, contents are undefined after reset
    data_t mem_q [BANK_WORDS];

    // Writes touch only the enabled byte lanes of the addressed word
    always_ff @(posedge clk_i) begin
        if (req_i && !wen_i) begin
            for (int lane = 0; lane < NR_LANES; lane++) begin
                if (be_i[lane]) begin
                    mem_q[idx_i][8*lane +: 8] <= wdata_i[8*lane +: 8];
                end
            end
        end
    end

    // Reads present the word on the output one cycle after acceptance
    // The output keeps its last read value on writes and idle cycles
    always_ff @(posedge clk_i) begin
        if (req_i && wen_i) begin
            rdata_o <= mem_q[idx_i];
        end
    end

endmodule : l2_sram_bank

//--- src/rr_arbiter.sv
// Round-robin arbiter with combinational one-hot grant and rotating priority pointer
`timescale 1ns/10ps

module rr_arbiter #(
    parameter int unsigned NR_MASTERS = 2
) (
    input  logic                                                  clk_i,
    input  logic                                                  reset_i,
    input  logic [NR_MASTERS-1:0]                                 req_i,
    output logic [NR_MASTERS-1:0]                                 gnt_o,
    output logic [(NR_MASTERS > 1 ? $clog2(NR_MASTERS) : 1)-1:0]  gnt_idx_o
);

    // Master index width, at least one bit for a single master
    localparam int unsigned IDX_W = (NR_MASTERS > 1) ? $clog2(NR_MASTERS) : 1;

    typedef logic [IDX_W-1:0] mst_idx_t;

    // Master with the highest priority in the current cycle
    mst_idx_t ptr_q;
    logic     gnt_any;

    // Scan from the pointer upwards with wrap-around and take the first requester
    always_comb begin
        int unsigned cand;
        gnt_o     = '0;
        gnt_idx_o = '0;
        gnt_any   = 1'b0;
        for (int unsigned off = 0; off < NR_MASTERS; off++) begin
            cand = (int'(ptr_q) + off) % NR_MASTERS;
            if (!gnt_any && req_i[cand]) begin
                gnt_any     = 1'b1;
                gnt_o[cand] = 1'b1;
                gnt_idx_o   = mst_idx_t'(cand);
            end
        end
    end

    // After a grant the winner drops to lowest priority
    // This bounds the wait of any requester to NR_MASTERS-1 grants
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_q <= '0;
        end else if (gnt_any) begin
            if (gnt_idx_o == mst_idx_t'(NR_MASTERS - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= gnt_idx_o + mst_idx_t'(1);
            end
        end
    end

endmodule : rr_arbiter

//--- src/l2_interconnect_pkg.sv
// Shared bus types, L2 region base address and error response word for the L2 interconnect
package l2_interconnect_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    // Byte address width seen by every master
    localparam int unsigned ADDR_WIDTH = 32;

    // Data word width of the masters and of every SRAM bank
    localparam int unsigned DATA_WIDTH = 32;

    // One byte enable per byte lane of a data word
    localparam int unsigned BE_WIDTH = DATA_WIDTH / 8;

    //////////////////////////////////////////////////
    // Bus types
    //////////////////////////////////////////////////

    // Byte address of a request
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Write data and read data word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Byte enables, bit n qualifies bits 8n+7 down to 8n of the word
    typedef logic [BE_WIDTH-1:0] be_t;

    //////////////////////////////////////////////////
    // Address map and error response
    //////////////////////////////////////////////////

    // Start of the word-interleaved L2 region
    // The region size follows from the bank count and depth of the instance
    localparam addr_t L2_BASE_ADDR = 32'h1C00_0000;

    // Read data returned for accesses that miss the L2 region
    // Together with r_opc set it marks a bus error towards the master
    localparam data_t ERROR_RESPONSE = 32'hBADACCE5;

endpackage : l2_interconnect_pkg
